/* include/spi_engine_settings.svh */
`ifndef SPI_ENGINE_SETTINGS_SVH
`define SPI_ENGINE_SETTINGS_SVH

// Width of one SPI data word
`define SPI_DATA_WIDTH 8

// FIFO address widths, depth is 2**AW
`define CMD_FIFO_AW 4
`define SDO_FIFO_AW 5
`define SDI_FIFO_AW 5

// Host register port
`define UP_ADDR_WIDTH 8

// Identification registers
`define CORE_VERSION 32'h0001_0071
`define CORE_ID 32'h0000_5e01

// clk cycles per half period of spi_sclk
`define SPI_CLK_DIV 2

`endif

/* logic/spi_engine_pkg.sv */
`default_nettype none

`include "spi_engine_settings.svh"

package spi_engine_pkg;

  typedef logic [`SPI_DATA_WIDTH-1:0] spi_word_t;

  typedef enum logic [3:0] {
    OP_TRANSFER = 4'd1,
    OP_SYNC     = 4'd3
  } spi_opcode_t;

  // Command word as written by the host
  typedef struct packed {
    spi_opcode_t opcode;
    logic [1:0]  rsvd;
    logic        wr;
    logic        rd;
    logic [7:0]  arg;
  } spi_cmd_t;

  localparam logic [`UP_ADDR_WIDTH-1:0] REG_VERSION     = 8'h00;
  localparam logic [`UP_ADDR_WIDTH-1:0] REG_ID          = 8'h01;
  localparam logic [`UP_ADDR_WIDTH-1:0] REG_SCRATCH     = 8'h02;
  localparam logic [`UP_ADDR_WIDTH-1:0] REG_SW_RESET    = 8'h10;
  localparam logic [`UP_ADDR_WIDTH-1:0] REG_IRQ_MASK    = 8'h20;
  localparam logic [`UP_ADDR_WIDTH-1:0] REG_IRQ_PENDING = 8'h21;
  localparam logic [`UP_ADDR_WIDTH-1:0] REG_IRQ_SOURCE  = 8'h22;
  localparam logic [`UP_ADDR_WIDTH-1:0] REG_SYNC_ID     = 8'h30;
  localparam logic [`UP_ADDR_WIDTH-1:0] REG_CMD_ROOM    = 8'h34;
  localparam logic [`UP_ADDR_WIDTH-1:0] REG_SDO_ROOM    = 8'h35;
  localparam logic [`UP_ADDR_WIDTH-1:0] REG_SDI_LEVEL   = 8'h36;
  localparam logic [`UP_ADDR_WIDTH-1:0] REG_CMD_FIFO    = 8'h38;
  localparam logic [`UP_ADDR_WIDTH-1:0] REG_SDO_FIFO    = 8'h39;
  localparam logic [`UP_ADDR_WIDTH-1:0] REG_SDI_FIFO    = 8'h3a;
  localparam logic [`UP_ADDR_WIDTH-1:0] REG_SDI_PEEK    = 8'h3c;

endpackage

`default_nettype wire

/* logic/spi_stream_fifo.sv */
`default_nettype none

module spi_stream_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int ADDR_WIDTH = 4
) (
  input  wire                  clk,
  input  wire                  rstn,
  input  wire                  in_valid,
  input  wire payload_t        in_data,
  output logic                 in_ready,
  output logic                 out_valid,
  output payload_t             out_data,
  input  wire                  out_ready,
  output logic [ADDR_WIDTH:0]  count
);

  localparam int DEPTH = 2 ** ADDR_WIDTH;
  localparam logic [ADDR_WIDTH:0] FULL_COUNT = {1'b1, {ADDR_WIDTH{1'b0}}};

  payload_t mem [DEPTH];
  logic [ADDR_WIDTH-1:0] wr_ptr;
  logic [ADDR_WIDTH-1:0] rd_ptr;
  logic push;
  logic pop;

  assign in_ready  = count != FULL_COUNT;
  assign out_valid = count != '0;
  // Head word is visible without a pop
  assign out_data  = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // A push while full would carry the count past the depth
  assert property (@(posedge clk) disable iff (!rstn)
    count <= FULL_COUNT);

  // Pointer distance matches the fill count that drives out_valid
  assert property (@(posedge clk) disable iff (!rstn)
    (wr_ptr - rd_ptr) == count[ADDR_WIDTH-1:0]);

endmodule

`default_nettype wire

/* logic/spi_engine_regmap.sv */
`default_nettype none

`include "spi_engine_settings.svh"

module spi_engine_regmap (
  input  wire                             clk,
  input  wire                             rstn,
  input  wire                             up_wreq,
  input  wire [`UP_ADDR_WIDTH-1:0]        up_waddr,
  input  wire [31:0]                      up_wdata,
  output logic                            up_wack,
  input  wire                             up_rreq,
  input  wire [`UP_ADDR_WIDTH-1:0]        up_raddr,
  output logic [31:0]                     up_rdata,
  output logic                            up_rack,
  output logic                            irq,
  output logic                            sw_resetn,
  output logic                            cmd_wr_valid,
  output spi_engine_pkg::spi_cmd_t        cmd_wr_data,
  input  wire [`CMD_FIFO_AW:0]            cmd_count,
  output logic                            sdo_wr_valid,
  output spi_engine_pkg::spi_word_t       sdo_wr_data,
  input  wire [`SDO_FIFO_AW:0]            sdo_count,
  output logic                            sdi_rd_ready,
  input  wire spi_engine_pkg::spi_word_t  sdi_rd_data,
  input  wire [`SDI_FIFO_AW:0]            sdi_count,
  input  wire                             sync_valid,
  input  wire [7:0]                       sync_id
);

  import spi_engine_pkg::*;

  localparam logic [`CMD_FIFO_AW:0] CMD_DEPTH = {1'b1, {`CMD_FIFO_AW{1'b0}}};
  localparam logic [`SDO_FIFO_AW:0] SDO_DEPTH = {1'b1, {`SDO_FIFO_AW{1'b0}}};
  localparam logic [`SDI_FIFO_AW:0] SDI_DEPTH = {1'b1, {`SDI_FIFO_AW{1'b0}}};

  // Three quarters of each depth
  localparam logic [`CMD_FIFO_AW:0] CMD_WM = {3'b011, {(`CMD_FIFO_AW-2){1'b0}}};
  localparam logic [`SDO_FIFO_AW:0] SDO_WM = {3'b011, {(`SDO_FIFO_AW-2){1'b0}}};
  localparam logic [`SDI_FIFO_AW:0] SDI_WM = {3'b011, {(`SDI_FIFO_AW-2){1'b0}}};

  logic [31:0] scratch;
  logic        sw_reset;
  logic [3:0]  irq_mask;
  logic [3:0]  irq_source;
  logic [3:0]  irq_pending;
  logic [7:0]  last_sync_id;
  logic        sync_pending;
  logic [`CMD_FIFO_AW:0] cmd_room;
  logic [`SDO_FIFO_AW:0] sdo_room;
  logic cmd_almost_empty;
  logic sdo_almost_empty;
  logic sdi_almost_full;
  logic pending_clear;

  assign sw_resetn = !sw_reset;

  assign cmd_room = CMD_DEPTH - cmd_count;
  assign sdo_room = SDO_DEPTH - sdo_count;

  assign cmd_almost_empty = cmd_room >= CMD_WM;
  assign sdo_almost_empty = sdo_room >= SDO_WM;
  assign sdi_almost_full  = sdi_count >= SDI_WM;

  assign irq_source  = {sync_pending, sdi_almost_full, sdo_almost_empty, cmd_almost_empty};
  assign irq_pending = irq_mask & irq_source;

  // FIFO access straight from the host strobes
  assign cmd_wr_valid = up_wreq && up_waddr == REG_CMD_FIFO;
  assign cmd_wr_data  = spi_cmd_t'(up_wdata[15:0]);
  assign sdo_wr_valid = up_wreq && up_waddr == REG_SDO_FIFO;
  assign sdo_wr_data  = up_wdata[`SPI_DATA_WIDTH-1:0];
  assign sdi_rd_ready = up_rreq && up_raddr == REG_SDI_FIFO;

  assign pending_clear = up_wreq && up_waddr == REG_IRQ_PENDING && up_wdata[3];

  always_ff @(posedge clk) begin
    if (!rstn) begin
      up_wack  <= 1'b0;
      scratch  <= '0;
      sw_reset <= 1'b1;
      irq_mask <= '0;
    end else begin
      up_wack <= up_wreq;
      if (up_wreq) begin
        case (up_waddr)
          REG_SCRATCH:  scratch  <= up_wdata;
          REG_SW_RESET: sw_reset <= up_wdata[0];
          REG_IRQ_MASK: irq_mask <= up_wdata[3:0];
          default: ;
        endcase
      end
    end
  end

  // Sync state also clears on software reset
  always_ff @(posedge clk) begin
    if (!rstn || sw_reset) begin
      last_sync_id <= '0;
      sync_pending <= 1'b0;
    end else if (sync_valid) begin
      last_sync_id <= sync_id;
      sync_pending <= 1'b1;
    end else if (pending_clear) begin
      sync_pending <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      irq     <= 1'b0;
      up_rack <= 1'b0;
    end else begin
      irq     <= |irq_pending;
      up_rack <= up_rreq;
    end
  end

  always_ff @(posedge clk) begin
    if (up_rreq) begin
      case (up_raddr)
        REG_VERSION:     up_rdata <= `CORE_VERSION;
        REG_ID:          up_rdata <= `CORE_ID;
        REG_SCRATCH:     up_rdata <= scratch;
        REG_SW_RESET:    up_rdata <= 32'(sw_reset);
        REG_IRQ_MASK:    up_rdata <= 32'(irq_mask);
        REG_IRQ_PENDING: up_rdata <= 32'(irq_pending);
        REG_IRQ_SOURCE:  up_rdata <= 32'(irq_source);
        REG_SYNC_ID:     up_rdata <= 32'(last_sync_id);
        REG_CMD_ROOM:    up_rdata <= 32'(cmd_room);
        REG_SDO_ROOM:    up_rdata <= 32'(sdo_room);
        REG_SDI_LEVEL:   up_rdata <= 32'(sdi_count);
        // Empty SDI FIFO reads as zero
        REG_SDI_FIFO,
        REG_SDI_PEEK:    up_rdata <= (sdi_count != '0) ? 32'(sdi_rd_data) : '0;
        default:         up_rdata <= '0;
      endcase
    end
  end

  // Fill counts stay within the depths so room never wraps
  assert property (@(posedge clk) disable iff (!rstn)
    cmd_count <= CMD_DEPTH && sdo_count <= SDO_DEPTH && sdi_count <= SDI_DEPTH);

endmodule

`default_nettype wire

/* logic/spi_exec_core.sv */
`default_nettype none

`include "spi_engine_settings.svh"

module spi_exec_core (
  input  wire                             clk,
  input  wire                             rstn,
  input  wire                             cmd_valid,
  input  wire spi_engine_pkg::spi_cmd_t   cmd_data,
  output logic                            cmd_ready,
  input  wire                             sdo_valid,
  input  wire spi_engine_pkg::spi_word_t  sdo_data,
  output logic                            sdo_ready,
  output logic                            sdi_valid,
  output spi_engine_pkg::spi_word_t       sdi_data,
  input  wire                             sdi_ready,
  output logic                            sync_valid,
  output logic [7:0]                      sync_id,
  output logic                            spi_sclk,
  output logic                            spi_cs_n,
  output logic                            spi_sdo,
  input  wire                             spi_sdi
);

  import spi_engine_pkg::*;

  localparam int W = `SPI_DATA_WIDTH;
  localparam int DIV_W = $clog2(`SPI_CLK_DIV + 1);
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`SPI_CLK_DIV - 1);
  localparam int BIT_W = $clog2(W);
  localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(W - 1);

  typedef enum logic [2:0] {
    S_IDLE,
    S_LOAD,
    S_SHIFT,
    S_STORE,
    S_FINISH
  } state_t;

  state_t state;
  logic [DIV_W-1:0] div_cnt;
  logic [BIT_W-1:0] bit_cnt;
  logic [7:0] word_cnt;
  logic wr_en;
  logic rd_en;
  spi_word_t shift_reg;
  logic sdi_bit;
  logic is_transfer;
  logic half_done;
  logic load_ok;
  logic store_done;

  assign is_transfer = cmd_data.opcode == OP_TRANSFER;
  assign half_done   = div_cnt == DIV_LAST;
  // Wait for a word to send and for room to keep the received one
  assign load_ok     = (!wr_en || sdo_valid) && (!rd_en || sdi_ready);
  assign store_done  = !rd_en || sdi_ready;

  // Non-transfer commands are consumed straight from idle
  assign cmd_ready = (state == S_IDLE && cmd_valid && !is_transfer) || state == S_FINISH;
  assign sdo_ready = state == S_LOAD && wr_en && load_ok;
  assign sdi_valid = state == S_STORE && rd_en;
  assign sdi_data  = shift_reg;

  assign sync_valid = state == S_IDLE && cmd_valid && cmd_data.opcode == OP_SYNC;
  assign sync_id    = cmd_data.arg;

  // MSB first
  assign spi_sdo = shift_reg[W-1];

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state    <= S_IDLE;
      spi_cs_n <= 1'b1;
      spi_sclk <= 1'b0;
      div_cnt  <= '0;
      bit_cnt  <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (cmd_valid && is_transfer) begin
            state <= S_LOAD;
          end
        end
        S_LOAD: begin
          if (load_ok) begin
            spi_cs_n <= 1'b0;
            div_cnt  <= '0;
            bit_cnt  <= '0;
            state    <= S_SHIFT;
          end
        end
        S_SHIFT: begin
          if (half_done) begin
            div_cnt  <= '0;
            spi_sclk <= !spi_sclk;
            // Falling edge closes a bit
            if (spi_sclk) begin
              if (bit_cnt == BIT_LAST) begin
                state <= S_STORE;
              end else begin
                bit_cnt <= bit_cnt + 1'b1;
              end
            end
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
        S_STORE: begin
          if (store_done) begin
            state <= (word_cnt == '0) ? S_FINISH : S_LOAD;
          end
        end
        S_FINISH: begin
          spi_cs_n <= 1'b1;
          state    <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_IDLE && cmd_valid && is_transfer) begin
      wr_en    <= cmd_data.wr;
      rd_en    <= cmd_data.rd;
      word_cnt <= cmd_data.arg;
    end
    if (state == S_LOAD && load_ok) begin
      shift_reg <= wr_en ? sdo_data : '0;
    end
    if (state == S_SHIFT && half_done) begin
      if (!spi_sclk) begin
        sdi_bit <= spi_sdi;
      end else begin
        shift_reg <= {shift_reg[W-2:0], sdi_bit};
      end
    end
    if (state == S_STORE && store_done && word_cnt != '0) begin
      word_cnt <= word_cnt - 1'b1;
    end
  end

  assert property (@(posedge clk) disable iff (!rstn)
    state == S_IDLE |-> spi_cs_n);

  assert property (@(posedge clk) disable iff (!rstn)
    spi_cs_n |-> !spi_sclk);

endmodule

`default_nettype wire

/* logic/spi_engine_top.sv */
`default_nettype none

`include "spi_engine_settings.svh"

module spi_engine_top (
  input  wire                       clk,
  input  wire                       rstn,
  input  wire                       up_wreq,
  input  wire [`UP_ADDR_WIDTH-1:0]  up_waddr,
  input  wire [31:0]                up_wdata,
  output logic                      up_wack,
  input  wire                       up_rreq,
  input  wire [`UP_ADDR_WIDTH-1:0]  up_raddr,
  output logic [31:0]               up_rdata,
  output logic                      up_rack,
  output logic                      irq,
  output logic                      spi_sclk,
  output logic                      spi_cs_n,
  output logic                      spi_sdo,
  input  wire                       spi_sdi
);

  import spi_engine_pkg::*;

  logic sw_resetn;
  logic core_rstn;

  logic cmd_wr_valid;
  spi_cmd_t cmd_wr_data;
  logic [`CMD_FIFO_AW:0] cmd_count;
  logic cmd_valid;
  logic cmd_ready;
  spi_cmd_t cmd_data;

  logic sdo_wr_valid;
  spi_word_t sdo_wr_data;
  logic [`SDO_FIFO_AW:0] sdo_count;
  logic sdo_valid;
  logic sdo_ready;
  spi_word_t sdo_data;

  logic sdi_rd_ready;
  spi_word_t sdi_rd_data;
  logic [`SDI_FIFO_AW:0] sdi_count;
  logic sdi_valid;
  logic sdi_ready;
  spi_word_t sdi_data;

  logic sync_valid;
  logic [7:0] sync_id;

  // FIFOs and core stay in reset until the host releases them
  assign core_rstn = rstn && sw_resetn;

  spi_engine_regmap regmap (
    .clk          (clk),
    .rstn         (rstn),
    .up_wreq      (up_wreq),
    .up_waddr     (up_waddr),
    .up_wdata     (up_wdata),
    .up_wack      (up_wack),
    .up_rreq      (up_rreq),
    .up_raddr     (up_raddr),
    .up_rdata     (up_rdata),
    .up_rack      (up_rack),
    .irq          (irq),
    .sw_resetn    (sw_resetn),
    .cmd_wr_valid (cmd_wr_valid),
    .cmd_wr_data  (cmd_wr_data),
    .cmd_count    (cmd_count),
    .sdo_wr_valid (sdo_wr_valid),
    .sdo_wr_data  (sdo_wr_data),
    .sdo_count    (sdo_count),
    .sdi_rd_ready (sdi_rd_ready),
    .sdi_rd_data  (sdi_rd_data),
    .sdi_count    (sdi_count),
    .sync_valid   (sync_valid),
    .sync_id      (sync_id)
  );

  spi_stream_fifo #(
    .payload_t  (spi_cmd_t),
    .ADDR_WIDTH (`CMD_FIFO_AW)
  ) cmd_fifo (
    .clk       (clk),
    .rstn      (core_rstn),
    .in_valid  (cmd_wr_valid),
    .in_data   (cmd_wr_data),
    .in_ready  (),
    .out_valid (cmd_valid),
    .out_data  (cmd_data),
    .out_ready (cmd_ready),
    .count     (cmd_count)
  );

  spi_stream_fifo #(
    .payload_t  (spi_word_t),
    .ADDR_WIDTH (`SDO_FIFO_AW)
  ) sdo_fifo (
    .clk       (clk),
    .rstn      (core_rstn),
    .in_valid  (sdo_wr_valid),
    .in_data   (sdo_wr_data),
    .in_ready  (),
    .out_valid (sdo_valid),
    .out_data  (sdo_data),
    .out_ready (sdo_ready),
    .count     (sdo_count)
  );

  spi_stream_fifo #(
    .payload_t  (spi_word_t),
    .ADDR_WIDTH (`SDI_FIFO_AW)
  ) sdi_fifo (
    .clk       (clk),
    .rstn      (core_rstn),
    .in_valid  (sdi_valid),
    .in_data   (sdi_data),
    .in_ready  (sdi_ready),
    .out_valid (),
    .out_data  (sdi_rd_data),
    .out_ready (sdi_rd_ready),
    .count     (sdi_count)
  );

  spi_exec_core exec_core (
    .clk        (clk),
    .rstn       (core_rstn),
    .cmd_valid  (cmd_valid),
    .cmd_data   (cmd_data),
    .cmd_ready  (cmd_ready),
    .sdo_valid  (sdo_valid),
    .sdo_data   (sdo_data),
    .sdo_ready  (sdo_ready),
    .sdi_valid  (sdi_valid),
    .sdi_data   (sdi_data),
    .sdi_ready  (sdi_ready),
    .sync_valid (sync_valid),
    .sync_id    (sync_id),
    .spi_sclk   (spi_sclk),
    .spi_cs_n   (spi_cs_n),
    .spi_sdo    (spi_sdo),
    .spi_sdi    (spi_sdi)
  );

endmodule

`default_nettype wire

/* sim/tb_clk_gen.sv */
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 5
) (
  output logic clk,
  output logic rstn
);

  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Reset low for the first few edges
  initial begin
    rstn = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rstn <= 1'b1;
  end

endmodule

`default_nettype wire

/* sim/tb_spi_engine.sv */
`default_nettype none

`include "spi_engine_settings.svh"

module tb_spi_engine;

  timeunit 1ns;
  timeprecision 1ps;

  import spi_engine_pkg::*;

  localparam int CMD_DEPTH = 1 << `CMD_FIFO_AW;
  localparam int SDO_DEPTH = 1 << `SDO_FIFO_AW;
  localparam int SDI_DEPTH = 1 << `SDI_FIFO_AW;
  localparam logic [3:0] TRANSFER_OP = 4'd1;
  localparam logic [3:0] SYNC_OP = 4'd3;
  localparam int ACK_LIMIT = 8;
  localparam int POLL_LIMIT = 200;
  localparam int IRQ_LIMIT = 20;

  logic clk;
  logic rstn;
  logic up_wreq;
  logic [`UP_ADDR_WIDTH-1:0] up_waddr;
  logic [31:0] up_wdata;
  logic up_wack;
  logic up_rreq;
  logic [`UP_ADDR_WIDTH-1:0] up_raddr;
  logic [31:0] up_rdata;
  logic up_rack;
  logic irq;
  logic spi_sclk;
  logic spi_cs_n;
  logic spi_sdo;
  logic spi_sdi;

  int value_errors = 0;
  int timeout_errors = 0;
  int cs_falls = 0;
  logic [31:0] rng_state;
  logic sampled_bits[$];
  logic [7:0] sent_words[$];

  // Loopback
  assign spi_sdi = spi_sdo;

  tb_clk_gen clk_gen (
    .clk  (clk),
    .rstn (rstn)
  );

  spi_engine_top DUT (
    .clk      (clk),
    .rstn     (rstn),
    .up_wreq  (up_wreq),
    .up_waddr (up_waddr),
    .up_wdata (up_wdata),
    .up_wack  (up_wack),
    .up_rreq  (up_rreq),
    .up_raddr (up_raddr),
    .up_rdata (up_rdata),
    .up_rack  (up_rack),
    .irq      (irq),
    .spi_sclk (spi_sclk),
    .spi_cs_n (spi_cs_n),
    .spi_sdo  (spi_sdo),
    .spi_sdi  (spi_sdi)
  );

  // SPI slave view sampling on the rising edge in mode 0
  always @(posedge spi_sclk) begin
    if (spi_cs_n == 1'b0) begin
      sampled_bits.push_back(spi_sdo);
    end
  end

  always @(negedge spi_cs_n) begin
    cs_falls++;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Command layout with opcode in 15:12, write in 9, read in 8 and argument in 7:0
  function automatic logic [31:0] cmd_word(input logic [3:0] op, input logic wr,
                                           input logic rd, input logic [7:0] arg);
    return {16'h0000, op, 2'b00, wr, rd, arg};
  endfunction

  function automatic logic [31:0] source_model(input int cmd_room, input int sdo_room,
                                               input int sdi_level, input logic sync);
    logic [31:0] s;
    s = '0;
    s[0] = cmd_room * 4 >= CMD_DEPTH * 3;
    s[1] = sdo_room * 4 >= SDO_DEPTH * 3;
    s[2] = sdi_level * 4 >= SDI_DEPTH * 3;
    s[3] = sync;
    return s;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      value_errors++;
      $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic up_write(input logic [`UP_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
    int cycles;
    @(posedge clk);
    up_wreq  <= 1'b1;
    up_waddr <= addr;
    up_wdata <= data;
    @(posedge clk);
    up_wreq <= 1'b0;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (up_wack !== 1'b1 && cycles < ACK_LIMIT);
    assert (up_wack === 1'b1) else begin
      timeout_errors++;
      $display("Timeout at %0t, write to address %0h was never acknowledged", $time, addr);
    end
  endtask

  task automatic up_read(input logic [`UP_ADDR_WIDTH-1:0] addr, output logic [31:0] data);
    int cycles;
    @(posedge clk);
    up_rreq  <= 1'b1;
    up_raddr <= addr;
    @(posedge clk);
    up_rreq <= 1'b0;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (up_rack !== 1'b1 && cycles < ACK_LIMIT);
    data = up_rdata;
    assert (up_rack === 1'b1) else begin
      timeout_errors++;
      $display("Timeout at %0t, read of address %0h was never acknowledged", $time, addr);
    end
  endtask

  task automatic wait_for_reg(input logic [`UP_ADDR_WIDTH-1:0] addr, input logic [31:0] exp,
                              input string name);
    logic [31:0] val;
    int tries;
    tries = 0;
    up_read(addr, val);
    while (val !== exp && tries < POLL_LIMIT) begin
      up_read(addr, val);
      tries++;
    end
    assert (val === exp) else begin
      timeout_errors++;
      $display("Timeout at %0t, %s never reached %0h", $time, name, exp);
    end
  endtask

  task automatic wait_for_irq(input logic exp);
    int cycles;
    cycles = 0;
    while (irq !== exp && cycles < IRQ_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    assert (irq === exp) else begin
      timeout_errors++;
      $display("Timeout at %0t, irq did not change to %0b", $time, exp);
    end
  endtask

  task automatic push_sdo_words(input int n);
    logic [7:0] w;
    for (int i = 0; i < n; i++) begin
      rng_state = xorshift32(rng_state);
      w = rng_state[7:0];
      sent_words.push_back(w);
      up_write(REG_SDO_FIFO, 32'(w));
    end
  endtask

  // Bits on the bus against the words sent MSB first
  task automatic check_sdo_bits(input int bit_base, input int fall_base);
    int nbits;
    nbits = sampled_bits.size() - bit_base;
    check_value("spi_cs_n falls", 32'(cs_falls - fall_base), 32'd1);
    check_value("spi_cs_n", 32'(spi_cs_n), 32'd1);
    check_value("spi_sclk", 32'(spi_sclk), 32'd0);
    check_value("sampled bit count", 32'(nbits), 32'(sent_words.size() * 8));
    if (nbits == sent_words.size() * 8) begin
      foreach (sent_words[w]) begin
        for (int b = 0; b < 8; b++) begin
          check_value($sformatf("spi_sdo word %0d bit %0d", w, 7 - b),
                      32'(sampled_bits[bit_base + w * 8 + b]), 32'(sent_words[w][7 - b]));
        end
      end
    end
  endtask

  task automatic check_reset_values();
    logic [31:0] val;
    logic [31:0] pattern;
    check_value("spi_cs_n", 32'(spi_cs_n), 32'd1);
    check_value("spi_sclk", 32'(spi_sclk), 32'd0);
    check_value("up_wack", 32'(up_wack), 32'd0);
    check_value("up_rack", 32'(up_rack), 32'd0);
    up_read(REG_VERSION, val);
    check_value("REG_VERSION", val, `CORE_VERSION);
    up_read(REG_ID, val);
    check_value("REG_ID", val, `CORE_ID);
    up_read(REG_SW_RESET, val);
    check_value("REG_SW_RESET", val, 32'd1);
    rng_state = xorshift32(rng_state);
    pattern = rng_state;
    up_write(REG_SCRATCH, pattern);
    up_read(REG_SCRATCH, val);
    check_value("REG_SCRATCH", val, pattern);
    check_value("irq", 32'(irq), 32'd0);
  endtask

  task automatic write_only_transfer();
    int bit_base;
    int fall_base;
    logic [31:0] val;
    up_write(REG_SW_RESET, 32'd0);
    sent_words.delete();
    push_sdo_words(4);
    bit_base = sampled_bits.size();
    fall_base = cs_falls;
    up_write(REG_CMD_FIFO, cmd_word(TRANSFER_OP, 1'b1, 1'b0, 8'd3));
    wait_for_reg(REG_CMD_ROOM, 32'(CMD_DEPTH), "REG_CMD_ROOM");
    check_sdo_bits(bit_base, fall_base);
    up_read(REG_SDI_LEVEL, val);
    check_value("REG_SDI_LEVEL", val, 32'd0);
  endtask

  task automatic loopback_transfer();
    int bit_base;
    int fall_base;
    logic [31:0] val;
    sent_words.delete();
    push_sdo_words(3);
    bit_base = sampled_bits.size();
    fall_base = cs_falls;
    up_write(REG_CMD_FIFO, cmd_word(TRANSFER_OP, 1'b1, 1'b1, 8'd2));
    wait_for_reg(REG_CMD_ROOM, 32'(CMD_DEPTH), "REG_CMD_ROOM");
    check_sdo_bits(bit_base, fall_base);
    up_read(REG_SDI_LEVEL, val);
    check_value("REG_SDI_LEVEL", val, 32'd3);
    // Two peeks must leave the FIFO untouched
    up_read(REG_SDI_PEEK, val);
    check_value("REG_SDI_PEEK", val, 32'(sent_words[0]));
    up_read(REG_SDI_PEEK, val);
    check_value("REG_SDI_PEEK", val, 32'(sent_words[0]));
    up_read(REG_SDI_LEVEL, val);
    check_value("REG_SDI_LEVEL", val, 32'd3);
    foreach (sent_words[i]) begin
      up_read(REG_SDI_FIFO, val);
      check_value($sformatf("REG_SDI_FIFO word %0d", i), val, 32'(sent_words[i]));
    end
    up_read(REG_SDI_LEVEL, val);
    check_value("REG_SDI_LEVEL", val, 32'd0);
  endtask

  task automatic sync_interrupt();
    logic [31:0] val;
    up_write(REG_CMD_FIFO, cmd_word(SYNC_OP, 1'b0, 1'b0, 8'h5a));
    wait_for_reg(REG_SYNC_ID, 32'h5a, "REG_SYNC_ID");
    up_read(REG_IRQ_SOURCE, val);
    check_value("REG_IRQ_SOURCE", val, source_model(CMD_DEPTH, SDO_DEPTH, 0, 1'b1));
    check_value("irq", 32'(irq), 32'd0);
    up_write(REG_IRQ_MASK, 32'h8);
    wait_for_irq(1'b1);
    up_read(REG_IRQ_PENDING, val);
    check_value("REG_IRQ_PENDING", val, 32'h8);
    up_write(REG_IRQ_PENDING, 32'h8);
    wait_for_irq(1'b0);
    up_read(REG_IRQ_SOURCE, val);
    check_value("REG_IRQ_SOURCE", val, source_model(CMD_DEPTH, SDO_DEPTH, 0, 1'b0));
  endtask

  task automatic fifo_room_and_reset();
    logic [31:0] val;
    up_read(REG_CMD_ROOM, val);
    check_value("REG_CMD_ROOM", val, 32'(CMD_DEPTH));
    up_read(REG_SDO_ROOM, val);
    check_value("REG_SDO_ROOM", val, 32'(SDO_DEPTH));
    up_read(REG_IRQ_SOURCE, val);
    check_value("REG_IRQ_SOURCE", val, source_model(CMD_DEPTH, SDO_DEPTH, 0, 1'b0));
    // No command is queued so the words stay put
    sent_words.delete();
    push_sdo_words(10);
    up_read(REG_SDO_ROOM, val);
    check_value("REG_SDO_ROOM", val, 32'(SDO_DEPTH - 10));
    up_read(REG_IRQ_SOURCE, val);
    check_value("REG_IRQ_SOURCE", val, source_model(CMD_DEPTH, SDO_DEPTH - 10, 0, 1'b0));
    up_write(REG_SW_RESET, 32'd1);
    up_read(REG_SDO_ROOM, val);
    check_value("REG_SDO_ROOM", val, 32'(SDO_DEPTH));
    up_read(REG_CMD_ROOM, val);
    check_value("REG_CMD_ROOM", val, 32'(CMD_DEPTH));
    up_read(REG_IRQ_SOURCE, val);
    check_value("REG_IRQ_SOURCE", val, source_model(CMD_DEPTH, SDO_DEPTH, 0, 1'b0));
  endtask

  initial begin
    int cycles;
    rng_state = 32'd9;
    up_wreq   = 1'b0;
    up_waddr  = '0;
    up_wdata  = '0;
    up_rreq   = 1'b0;
    up_raddr  = '0;
    cycles = 0;
    while (rstn !== 1'b1 && cycles < 50) begin
      @(posedge clk);
      cycles++;
    end
    assert (rstn === 1'b1) else begin
      timeout_errors++;
      $display("Timeout at %0t, reset was never released", $time);
    end
    check_reset_values();
    write_only_transfer();
    loopback_transfer();
    sync_interrupt();
    fifo_room_and_reset();
    $display("Errors: %0d value mismatches, %0d timeouts", value_errors, timeout_errors);
    if (value_errors + timeout_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
+incdir+include
logic/spi_engine_pkg.sv
logic/spi_stream_fifo.sv
logic/spi_engine_regmap.sv
logic/spi_exec_core.sv
logic/spi_engine_top.sv
sim/tb_clk_gen.sv
sim/tb_spi_engine.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the SPI engine testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f files.f --top-module tb_spi_engine \
  -Mdir "$BUILD_DIR" -o tb_spi_engine
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/tb_spi_engine" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -qF "*** TEST FAILED ***" "$LOG"; then
  exit 1
fi
exit 0
